//--- Makefile
# Verilator lint, build and simulation of the decode stage testbench

TOOL     = verilator
TOP      = dec_tb
FILELIST = src.f
FLAGS    = --timing --assert --timescale 1ns/1ns
OBJ_DIR  = obj_dir
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/dec.sv
// decode stage top level
// instruction buffer, decoder with scoreboard, register file

`timescale 1ns/1ns

`include "dec_defines.svh"

`default_nettype none

module dec
   import dec_pkg::*;
(
   input  logic       clk,
   input  logic       rst,           // synchronous, active high
   input  logic       fetch_valid,
   input  fetch_pkt_t fetch_pkt,
   output logic       fetch_ready,
   output logic       dec_valid,
   output dec_pkt_t   dec_pkt,
   input  logic       exe_ready,
   input  logic       wb_valid,      // no ready, always taken
   input  wb_pkt_t    wb_pkt
);

   logic                   ib_valid;
   fetch_pkt_t             ib_pkt;
   logic                   ib_pop;
   logic [`DEC_REG_AW-1:0] rs1_addr;
   logic [`DEC_REG_AW-1:0] rs2_addr;
   logic [`DEC_XLEN-1:0]   rs1_data;
   logic [`DEC_XLEN-1:0]   rs2_data;

   dec_ib_ctl instbuff (
      .clk, .rst,
      .fetch_valid, .fetch_pkt, .fetch_ready,
      .ib_valid, .ib_pkt, .ib_pop
   );

   dec_decode_ctl decode (
      .clk, .rst,
      .ib_valid, .ib_pkt, .ib_pop,
      .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
      .wb_valid, .wb_pkt,
      .dec_valid, .dec_pkt, .exe_ready
   );

   dec_gpr_ctl arf (
      .clk,
      .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
      .wb_valid, .wb_pkt
   );

endmodule

`default_nettype wire

//--- logic/dec_decode_ctl.sv
// field decode and immediate generation
// dependency scoreboard and issue handshake to execution

`timescale 1ns/1ns

`include "dec_defines.svh"

`default_nettype none

module dec_decode_ctl
   import dec_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   ib_valid,    // buffer head present
   input  fetch_pkt_t             ib_pkt,
   output logic                   ib_pop,      // head consumed
   output logic [`DEC_REG_AW-1:0] rs1_addr,
   output logic [`DEC_REG_AW-1:0] rs2_addr,
   input  logic [`DEC_XLEN-1:0]   rs1_data,
   input  logic [`DEC_XLEN-1:0]   rs2_data,
   input  logic                   wb_valid,
   input  wb_pkt_t                wb_pkt,
   output logic                   dec_valid,   // packet ready to issue
   output dec_pkt_t               dec_pkt,
   input  logic                   exe_ready
);

   inst_u                   inst;
   op_class_e               op_class;
   logic [`DEC_XLEN-1:0]    imm;
   logic                    rs1_en;
   logic                    rs2_en;
   logic                    rd_en;
   logic [`DEC_NUM_GPR-1:0] sb_q;          // one bit per reg, write in flight
   logic [`DEC_NUM_GPR-1:0] sb_d;
   logic                    rs1_busy;
   logic                    rs2_busy;
   logic                    rd_busy;
   logic                    issue;

   assign inst.raw = ib_pkt.inst;

   // **************************************************
   // opcode decode and immediates
   // **************************************************
   always_comb begin
      op_class = illegal;                  // unknown opcode default
      imm      = '0;
      rs1_en   = 1'b0;
      rs2_en   = 1'b0;
      rd_en    = 1'b0;
      case (inst.r.opcode)
         `DEC_OP_REG: begin
            op_class = alu_reg;
            rs1_en   = 1'b1;
            rs2_en   = 1'b1;
            rd_en    = 1'b1;
         end
         `DEC_OP_IMM: begin
            op_class = alu_imm;
            imm      = {{20{inst.i.imm12[11]}}, inst.i.imm12};           // i-type
            rs1_en   = 1'b1;
            rd_en    = 1'b1;
         end
         `DEC_OP_LOAD: begin
            op_class = load;
            imm      = {{20{inst.i.imm12[11]}}, inst.i.imm12};
            rs1_en   = 1'b1;
            rd_en    = 1'b1;
         end
         `DEC_OP_STORE: begin
            op_class = store;
            imm      = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};  // s-type
            rs1_en   = 1'b1;
            rs2_en   = 1'b1;
         end
         `DEC_OP_BRANCH: begin
            op_class = branch;
            imm      = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                        inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};   // b-type, even
            rs1_en   = 1'b1;
            rs2_en   = 1'b1;
         end
         `DEC_OP_JAL: begin
            op_class = jal;
            imm      = {{11{inst.raw[31]}}, inst.raw[31], inst.raw[19:12],
                        inst.raw[20], inst.raw[30:21], 1'b0};            // j-type
            rd_en    = 1'b1;
         end
         `DEC_OP_JALR: begin
            op_class = jalr;
            imm      = {{20{inst.i.imm12[11]}}, inst.i.imm12};
            rs1_en   = 1'b1;
            rd_en    = 1'b1;
         end
         `DEC_OP_LUI: begin
            op_class = lui;
            imm      = {inst.raw[31:12], 12'b0};                         // u-type
            rd_en    = 1'b1;
         end
         `DEC_OP_AUIPC: begin
            op_class = auipc;
            imm      = {inst.raw[31:12], 12'b0};
            rd_en    = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // unused source reads x0 so its data is zero
   assign rs1_addr = rs1_en ? inst.r.rs1 : '0;
   assign rs2_addr = rs2_en ? inst.r.rs2 : '0;

   // **************************************************
   // scoreboard and issue
   // **************************************************
   assign rs1_busy = (rs1_addr != '0) & sb_q[rs1_addr];
   assign rs2_busy = (rs2_addr != '0) & sb_q[rs2_addr];
   // one bit per reg cannot track two writes to the same rd
   assign rd_busy  = rd_en & (inst.r.rd != '0) & sb_q[inst.r.rd];

   assign dec_valid = ib_valid & ~rs1_busy & ~rs2_busy & ~rd_busy;
   assign issue     = dec_valid & exe_ready;
   assign ib_pop    = issue;

   always_comb begin
      sb_d = sb_q;
      if (wb_valid) sb_d[wb_pkt.rd] = 1'b0;                        // result landed
      if (issue && rd_en && inst.r.rd != '0) sb_d[inst.r.rd] = 1'b1;  // new producer
   end

   always_ff @(posedge clk) begin
      if (rst) sb_q <= '0;
      else     sb_q <= sb_d;
   end

   always_comb begin
      dec_pkt           = '0;
      dec_pkt.pc        = ib_pkt.pc;
      dec_pkt.op_class  = op_class;
      dec_pkt.funct3    = inst.r.funct3;
      dec_pkt.funct7_b5 = inst.r.funct7[5];
      dec_pkt.rd        = inst.r.rd;
      dec_pkt.rd_en     = rd_en;
      dec_pkt.rs1_data  = rs1_data;
      dec_pkt.rs2_data  = rs2_data;
      dec_pkt.imm       = imm;
      dec_pkt.illegal   = op_class == illegal;
   end

   // held packet must not move while execution stalls
   a_pkt_stable: assert property (@(posedge clk) disable iff (rst)
      dec_valid && !exe_ready |=> dec_valid && $stable(dec_pkt))
      else $error("dec_pkt changed under back-pressure");

   // results only come back for issued producers
   a_wb_pending: assert property (@(posedge clk) disable iff (rst)
      wb_valid && wb_pkt.rd != '0 |-> sb_q[wb_pkt.rd])
      else $error("writeback to x%0d with no write in flight", wb_pkt.rd);

endmodule

`default_nettype wire

//--- logic/dec_defines.svh
// widths and depths for the decode stage
// rv32i major opcodes

`ifndef DEC_DEFINES_SVH
`define DEC_DEFINES_SVH

`default_nettype none

// **************************************************
// sizes
// **************************************************
`define DEC_XLEN       32          // data and instruction width
`define DEC_REG_AW     5           // register address width
`define DEC_NUM_GPR    32          // architectural registers
`define DEC_IB_DEPTH   2           // instruction buffer entries, power of two

// **************************************************
// major opcodes
// **************************************************
`define DEC_OP_LUI     7'b0110111
`define DEC_OP_AUIPC   7'b0010111
`define DEC_OP_JAL     7'b1101111
`define DEC_OP_JALR    7'b1100111
`define DEC_OP_BRANCH  7'b1100011
`define DEC_OP_LOAD    7'b0000011
`define DEC_OP_STORE   7'b0100011
`define DEC_OP_IMM     7'b0010011
`define DEC_OP_REG     7'b0110011

`default_nettype wire

`endif

//--- logic/dec_gpr_ctl.sv
// architectural register file
// two combinational read ports and one write port, x0 hardwired

`timescale 1ns/1ns

`include "dec_defines.svh"

`default_nettype none

module dec_gpr_ctl
   import dec_pkg::*;
(
   input  logic                   clk,
   input  logic [`DEC_REG_AW-1:0] rs1_addr,
   input  logic [`DEC_REG_AW-1:0] rs2_addr,
   output logic [`DEC_XLEN-1:0]   rs1_data,
   output logic [`DEC_XLEN-1:0]   rs2_data,
   input  logic                   wb_valid,   // write strobe
   input  wb_pkt_t                wb_pkt
);

   logic [`DEC_XLEN-1:0] gpr [`DEC_NUM_GPR-1:1];  // no x0 storage, no reset

   // x0 reads as zero
   assign rs1_data = (rs1_addr == '0) ? '0 : gpr[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : gpr[rs2_addr];

   always_ff @(posedge clk) begin
      if (wb_valid && wb_pkt.rd != '0) begin
         gpr[wb_pkt.rd] <= wb_pkt.data;             // x0 writes dropped
      end
   end

   a_x0_zero: assert property (@(posedge clk)
      (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0))
      else $error("nonzero read data for x0");

endmodule

`default_nettype wire

//--- logic/dec_ib_ctl.sv
// instruction buffer between fetch and decode
// circular buffer with read and write pointers and a count

`timescale 1ns/1ns

`include "dec_defines.svh"

`default_nettype none

module dec_ib_ctl
   import dec_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       fetch_valid,     // fetch has a packet
   input  fetch_pkt_t fetch_pkt,
   output logic       fetch_ready,     // room for one more
   output logic       ib_valid,        // head entry present
   output fetch_pkt_t ib_pkt,          // oldest entry
   input  logic       ib_pop           // decoder issued the head
);

   localparam int unsigned DEPTH = `DEC_IB_DEPTH;
   localparam int unsigned PTR_W = $clog2(DEPTH);
   localparam int unsigned CNT_W = PTR_W + 1;
   localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

   fetch_pkt_t             mem [DEPTH];  // payload, no reset
   logic [PTR_W-1:0]       rd_ptr_q;
   logic [PTR_W-1:0]       wr_ptr_q;
   logic [CNT_W-1:0]       count_q;
   logic                   push;

   assign fetch_ready = count_q < FULL;
   assign ib_valid    = count_q != '0;
   assign ib_pkt      = mem[rd_ptr_q];
   assign push        = fetch_valid & fetch_ready;

   // **************************************************
   // pointers and count
   // **************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
         if (ib_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, ib_pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;          // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr_q] <= fetch_pkt;
   end

   // decoder only pops what it sees
   a_pop_needs_valid: assert property (@(posedge clk) disable iff (rst)
      ib_pop |-> ib_valid)
      else $error("ib_pop with empty buffer");

endmodule

`default_nettype wire

//--- logic/dec_pkg.sv
// decode stage types
// fetch, writeback and decode packets, operation class, instruction views

`include "dec_defines.svh"

`default_nettype none

package dec_pkg;

   // one fetched instruction
   typedef struct packed {
      logic [`DEC_XLEN-1:0] inst;      // raw instruction word
      logic [`DEC_XLEN-1:0] pc;        // its address
   } fetch_pkt_t;

   // one result back from execution
   typedef struct packed {
      logic [`DEC_REG_AW-1:0] rd;      // destination
      logic [`DEC_XLEN-1:0]   data;    // value written
   } wb_pkt_t;

   typedef enum logic [3:0] {
      alu_reg,                         // register-register alu
      alu_imm,                         // register-immediate alu
      load,
      store,
      branch,
      jal,
      jalr,
      lui,
      auipc,
      illegal                          // unknown opcode
   } op_class_e;

   // the instruction word in each format layout
   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm12;           // sign bit at 11
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm_hi;           // imm[11:5] or b-format bits
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;           // imm[4:0] or b-format bits
         logic [6:0] opcode;
      } s;
   } inst_u;

   // packet issued to execution
   typedef struct packed {
      logic [`DEC_XLEN-1:0]   pc;
      op_class_e              op_class;
      logic [2:0]             funct3;
      logic                   funct7_b5;  // sub/sra select
      logic [`DEC_REG_AW-1:0] rd;
      logic                   rd_en;      // class writes rd
      logic [`DEC_XLEN-1:0]   rs1_data;
      logic [`DEC_XLEN-1:0]   rs2_data;
      logic [`DEC_XLEN-1:0]   imm;        // sign extended
      logic                   illegal;    // same as class illegal
   } dec_pkt_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+logic
logic/dec_pkg.sv
logic/dec_ib_ctl.sv
logic/dec_decode_ctl.sv
logic/dec_gpr_ctl.sv
logic/dec.sv
testbench/dec_tb.sv

//--- testbench/dec_tb.sv
// testbench for the decode stage
// random rv32i stream, reference decode, shadow register file and scoreboard
// execution model with delayed writeback, concurrent checks and report

`timescale 1ns/1ns

`include "dec_defines.svh"

`default_nettype none

module dec_tb
   import dec_pkg::*;
;

   localparam int NUM_INST    = 200;
   localparam int CLK_NS      = 20;
   localparam int WATCHDOG_NS = NUM_INST * 20 * CLK_NS;
   localparam int DRAIN_LIMIT = 200;       // cycles allowed to empty the pipe

   logic       clk;
   logic       rst;
   logic       fetch_valid;
   logic       fetch_ready;
   logic       dec_valid;
   logic       exe_ready;
   logic       wb_valid;
   logic       issue;
   fetch_pkt_t fetch_pkt;
   dec_pkt_t   dec_pkt;
   wb_pkt_t    wb_pkt;

   logic [31:0] rng;                       // xorshift state
   fetch_pkt_t  fetch_q [$];               // fetched, not yet issued
   logic [31:0] shadow [32];               // shadow register file
   logic [31:0] sb_shadow;                 // shadow scoreboard
   logic [4:0]  pend_rd [$];               // writebacks owed by execution
   int          pend_due [$];
   dec_pkt_t    exp_pkt;                   // expected packet for the head
   logic        exp_valid;
   logic        exp_rs1_used;
   logic        exp_rs2_used;
   logic        exp_src_pending;
   logic        push_now;                  // handshakes seen before the edge
   logic        issue_now;
   logic        wb_now;
   logic [31:0] next_pc;
   int          cycle;
   int          gen_count;
   int          fetched;
   int          issued;
   int          wb_count;
   int          drain_cycles;
   int          errors;

   dec dec_i (
      .clk, .rst,
      .fetch_valid, .fetch_pkt, .fetch_ready,
      .dec_valid, .dec_pkt, .exe_ready,
      .wb_valid, .wb_pkt
   );

   assign issue = dec_valid & exe_ready;

   always #(CLK_NS / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   // **************************************************
   // stimulus and reference decode
   // **************************************************
   function automatic logic [31:0] make_inst(int n);
      logic [31:0] w;
      logic [31:0] r;
      w = next_rand();
      r = next_rand();
      if (n < 7) begin                     // lui x1..x7 gives each a first value
         w[6:0]  = `DEC_OP_LUI;
         w[11:7] = 5'(n + 1);
         return w;
      end
      case (r % 11)
         0:       w[6:0] = `DEC_OP_LUI;
         1:       w[6:0] = `DEC_OP_AUIPC;
         2:       w[6:0] = `DEC_OP_JAL;
         3:       w[6:0] = `DEC_OP_JALR;
         4:       w[6:0] = `DEC_OP_BRANCH;
         5:       w[6:0] = `DEC_OP_LOAD;
         6:       w[6:0] = `DEC_OP_STORE;
         7:       w[6:0] = `DEC_OP_IMM;
         8:       w[6:0] = `DEC_OP_REG;
         9:       w[6:0] = 7'b0001111;      // fence, not decoded here
         default: w[6:0] = 7'b1110011;      // system, not decoded here
      endcase
      w[11:7]  = 5'(r[6:4]);               // x0..x7 keeps hazards frequent
      w[19:15] = 5'(r[9:7]);
      w[24:20] = 5'(r[12:10]);
      return w;
   endfunction

   function automatic void ref_decode(input logic [31:0] w, output dec_pkt_t p,
                                      output logic u1, output logic u2);
      op_class_e c;
      case (w[6:0])
         `DEC_OP_REG:    c = alu_reg;
         `DEC_OP_IMM:    c = alu_imm;
         `DEC_OP_LOAD:   c = load;
         `DEC_OP_STORE:  c = store;
         `DEC_OP_BRANCH: c = branch;
         `DEC_OP_JAL:    c = jal;
         `DEC_OP_JALR:   c = jalr;
         `DEC_OP_LUI:    c = lui;
         `DEC_OP_AUIPC:  c = auipc;
         default:        c = illegal;
      endcase
      p           = '0;
      p.op_class  = c;
      p.funct3    = w[14:12];
      p.funct7_b5 = w[30];
      p.rd        = w[11:7];
      p.rd_en     = c inside {alu_reg, alu_imm, load, jal, jalr, lui, auipc};
      p.illegal   = c == illegal;
      u1          = c inside {alu_reg, alu_imm, load, store, branch, jalr};
      u2          = c inside {alu_reg, store, branch};
      case (c)
         alu_imm, load, jalr: p.imm = {{20{w[31]}}, w[31:20]};
         store:      p.imm = {{20{w[31]}}, w[31:25], w[11:7]};
         branch:     p.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         jal:        p.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         lui, auipc: p.imm = {w[31:12], 12'b0};
         default:    p.imm = '0;
      endcase
   endfunction

   task automatic value_error(string name, logic [31:0] exp, logic [31:0] act);
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
   endtask

   task automatic check_failed(string what);
      errors++;
      $display("error at %0t ns: %s", $time, what);
   endtask

   // effects of the edge just passed on the reference model
   task automatic apply_handshakes();
      fetch_pkt_t head;
      dec_pkt_t   p;
      logic       u1;
      logic       u2;
      if (wb_now) begin
         if (wb_pkt.rd != '0) shadow[wb_pkt.rd] = wb_pkt.data;   // x0 stays zero
         sb_shadow[wb_pkt.rd] = 1'b0;
         wb_count++;
      end
      if (issue_now) begin
         issued++;                                               // every issue handshake
         if (fetch_q.size() != 0) begin
            head = fetch_q.pop_front();
            ref_decode(head.inst, p, u1, u2);
            if (p.rd_en) begin
               if (p.rd != '0) sb_shadow[p.rd] = 1'b1;
               pend_rd.push_back(p.rd);
               pend_due.push_back(cycle + int'(next_rand() % 6)); // lands 1 to 6 edges later
            end
         end
      end
      if (push_now) begin
         fetch_q.push_back(fetch_pkt);
         fetched++;
      end
   endtask

   task automatic drive_inputs();
      int idx;
      idx      = -1;
      wb_valid = 1'b0;
      for (int i = 0; i < pend_due.size(); i++) begin
         if (idx < 0 && pend_due[i] <= cycle) idx = i;             // oldest due result
      end
      if (idx >= 0) begin
         wb_valid     = 1'b1;
         wb_pkt.rd    = pend_rd[idx];
         wb_pkt.data  = next_rand();
         pend_rd.delete(idx);
         pend_due.delete(idx);
      end
      if (push_now || !fetch_valid) begin                          // else hold the packet
         fetch_valid = 1'b0;
         if (gen_count < NUM_INST && next_rand() % 4 != 0) begin
            fetch_valid    = 1'b1;
            fetch_pkt.inst = make_inst(gen_count);
            fetch_pkt.pc   = next_pc;
            next_pc += 4;
            gen_count++;
         end
      end
      exe_ready = next_rand() % 10 < 7;
   endtask

   task automatic refresh_expect();
      logic [31:0] w;
      exp_valid       = fetch_q.size() != 0;
      exp_src_pending = 1'b0;
      if (exp_valid) begin
         w = fetch_q[0].inst;
         ref_decode(w, exp_pkt, exp_rs1_used, exp_rs2_used);
         exp_pkt.pc       = fetch_q[0].pc;
         exp_pkt.rs1_data = shadow[w[19:15]];
         exp_pkt.rs2_data = shadow[w[24:20]];
         exp_src_pending  = (exp_rs1_used && sb_shadow[w[19:15]]) ||
                            (exp_rs2_used && sb_shadow[w[24:20]]);
      end
   endtask

   task automatic step();
      @(negedge clk);                      // outputs settled here
      push_now  = fetch_valid & fetch_ready;
      issue_now = dec_valid & exe_ready;
      wb_now    = wb_valid;
      @(posedge clk);
      #2;
      cycle++;
      apply_handshakes();
      drive_inputs();
      refresh_expect();
   endtask

   // **************************************************
   // checks
   // **************************************************
   a_rst_valid: assert property (@(posedge clk) $fell(rst) |-> !dec_valid)
      else value_error("dec_valid", 0, $sampled(dec_valid));
   a_rst_ready: assert property (@(posedge clk) $fell(rst) |-> fetch_ready)
      else value_error("fetch_ready", 1, $sampled(fetch_ready));
   a_order: assert property (@(posedge clk) disable iff (rst) dec_valid |-> exp_valid)
      else check_failed("dec_valid high with no fetched instruction outstanding");
   a_pc: assert property (@(posedge clk) disable iff (rst) issue |-> dec_pkt.pc == exp_pkt.pc)
      else value_error("dec_pkt.pc", $sampled(exp_pkt.pc), $sampled(dec_pkt.pc));
   a_class: assert property (@(posedge clk) disable iff (rst)
      issue |-> dec_pkt.op_class == exp_pkt.op_class)
      else value_error("dec_pkt.op_class", $sampled(exp_pkt.op_class), $sampled(dec_pkt.op_class));
   a_rd: assert property (@(posedge clk) disable iff (rst) issue |-> dec_pkt.rd == exp_pkt.rd)
      else value_error("dec_pkt.rd", $sampled(exp_pkt.rd), $sampled(dec_pkt.rd));
   a_rd_en: assert property (@(posedge clk) disable iff (rst)
      issue |-> dec_pkt.rd_en == exp_pkt.rd_en)
      else value_error("dec_pkt.rd_en", $sampled(exp_pkt.rd_en), $sampled(dec_pkt.rd_en));
   a_funct3: assert property (@(posedge clk) disable iff (rst)
      issue |-> dec_pkt.funct3 == exp_pkt.funct3)
      else value_error("dec_pkt.funct3", $sampled(exp_pkt.funct3), $sampled(dec_pkt.funct3));
   a_funct7: assert property (@(posedge clk) disable iff (rst)
      issue |-> dec_pkt.funct7_b5 == exp_pkt.funct7_b5)
      else value_error("dec_pkt.funct7_b5", $sampled(exp_pkt.funct7_b5),
                       $sampled(dec_pkt.funct7_b5));
   a_imm: assert property (@(posedge clk) disable iff (rst) issue |-> dec_pkt.imm == exp_pkt.imm)
      else value_error("dec_pkt.imm", $sampled(exp_pkt.imm), $sampled(dec_pkt.imm));
   a_illegal: assert property (@(posedge clk) disable iff (rst)
      issue |-> dec_pkt.illegal == exp_pkt.illegal)
      else value_error("dec_pkt.illegal", $sampled(exp_pkt.illegal), $sampled(dec_pkt.illegal));
   a_rs1: assert property (@(posedge clk) disable iff (rst)
      issue && exp_rs1_used |-> dec_pkt.rs1_data === exp_pkt.rs1_data)
      else value_error("dec_pkt.rs1_data", $sampled(exp_pkt.rs1_data), $sampled(dec_pkt.rs1_data));
   a_rs2: assert property (@(posedge clk) disable iff (rst)
      issue && exp_rs2_used |-> dec_pkt.rs2_data === exp_pkt.rs2_data)
      else value_error("dec_pkt.rs2_data", $sampled(exp_pkt.rs2_data), $sampled(dec_pkt.rs2_data));
   a_stall: assert property (@(posedge clk) disable iff (rst) issue |-> !exp_src_pending)
      else check_failed("instruction issued while a source register was pending");
   a_hold: assert property (@(posedge clk) disable iff (rst)
      dec_valid && !exe_ready |=> dec_valid && $stable(dec_pkt))
      else check_failed("dec_valid or dec_pkt changed under back-pressure");

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog: run still going after %0d ns", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      fetch_valid = 1'b0;
      fetch_pkt   = '0;
      exe_ready   = 1'b0;
      wb_valid    = 1'b0;
      wb_pkt      = '0;
      rng         = 32'h3c91;
      next_pc     = 32'h0000_1000;
      sb_shadow   = '0;
      exp_valid   = 1'b0;
      exp_pkt     = '0;
      foreach (shadow[i]) shadow[i] = 'x;  // not reset in the DUT either
      shadow[0]   = '0;
      repeat (5) @(posedge clk);
      #2 rst = 1'b0;
      @(posedge clk);
      #1;
      $display("test reset: done, %0d errors so far", errors);
      while (fetched < NUM_INST) step();
      $display("test stream: %0d fetched, %0d issued, %0d errors so far", fetched, issued, errors);
      while ((fetch_q.size() != 0 || pend_rd.size() != 0 || wb_valid) &&
             drain_cycles < DRAIN_LIMIT) begin
         step();
         drain_cycles++;
      end
      a_empty: assert (fetch_q.size() == 0)
         else check_failed("fetched instructions left over at the end");
      a_count: assert (issued == fetched)
         else value_error("issued count", fetched, issued);
      $display("test drain: %0d issued, %0d writebacks, %0d errors so far",
               issued, wb_count, errors);
      $display("summary: %0d fetched, %0d issued, %0d writebacks, %0d errors",
               fetched, issued, wb_count, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
